/* common/lsu_pkg.sv */
// shared widths, types and bus structs of the load/store forwarding unit
// the data path is fixed at a 32-bit byte address and one 64-bit dword per bus beat
// the two lanes of a stage are the dwords at lo_dw and hi_dw, hi is only used when dual
package lsu_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 64;
  localparam int BYTE_W = 8;               // byte lanes per dword
  localparam int OFS_W  = 3;               // byte offset inside a dword
  localparam int DW_W   = ADDR_W - OFS_W;
  localparam int TAG_W  = 4;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DW_W-1:0]   dw_addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [BYTE_W-1:0] byteen_t;
  typedef logic [TAG_W-1:0]  tag_t;

  typedef enum logic [1:0] {
    size_byte,
    size_half,
    size_word,
    size_dword
  } ldst_size_e;

  typedef struct packed {
    logic       valid;
    logic       load;
    logic       store;
    ldst_size_e size;
    tag_t       tag;
    addr_t      addr;
    data_t      data;
  } lsu_req_t;

  typedef struct packed {
    logic     valid;
    logic     load;
    logic     store;
    tag_t     tag;
    logic     dual;     // access spills into the next dword
    dw_addr_t lo_dw;
    dw_addr_t hi_dw;
    byteen_t  lo_be;
    byteen_t  hi_be;
    data_t    lo_data;
    data_t    hi_data;
  } lsu_stage_t;

  typedef struct packed {
    byteen_t lo_hit;
    byteen_t hi_hit;
    data_t   lo_fwd;
    data_t   hi_fwd;
    data_t   data;      // realigned, unused bytes zero
    logic    full_hit;
  } fwd_res_t;

  typedef struct packed {
    logic     cyc;
    logic     stb;
    logic     we;
    dw_addr_t adr;
    data_t    dat;
    byteen_t  sel;
  } wb_m2s_t;

  typedef struct packed {
    logic  ack;
    data_t dat;
  } wb_s2m_t;

  typedef struct packed {
    logic  valid;
    tag_t  tag;
    data_t data;
  } lsu_rsp_t;

  // replace the bytes of cur that are selected in sel by those of src
  function automatic data_t byte_merge(data_t cur, data_t src, byteen_t sel);
    data_t res;
    res = cur;
    for (int b = 0; b < BYTE_W; b++) begin
      if (sel[b]) res[8*b +: 8] = src[8*b +: 8];
    end
    return res;
  endfunction

  // shift the hi:lo pair back to byte 0 and clear the bytes outside the access
  // the offset is the lowest enabled byte of the lo lane
  function automatic data_t realign(data_t hi, data_t lo, byteen_t hi_be, byteen_t lo_be);
    logic [2*DATA_W-1:0] pair;
    logic [2*BYTE_W-1:0] be_pair;
    logic [OFS_W-1:0]    ofs;
    data_t               res;
    ofs = '0;
    for (int i = BYTE_W - 1; i >= 0; i--) begin
      if (lo_be[i]) ofs = OFS_W'(i);
    end
    pair    = {hi, lo} >> {ofs, 3'b000};
    be_pair = {hi_be, lo_be} >> ofs;
    for (int b = 0; b < BYTE_W; b++) begin
      res[8*b +: 8] = be_pair[b] ? pair[8*b +: 8] : 8'h00;
    end
    return res;
  endfunction

endpackage

/* fwd/lsu_fwd_match.sv */
// store to load forwarding for the load in dc2
// older stores are those in dc3, dc4 and dc5, the youngest one wins per byte
// purely combinational, the result is registered by the pipe as dc3_fwd
module lsu_fwd_match (
  input  lsu_pkg::lsu_stage_t dc2,
  input  lsu_pkg::lsu_stage_t dc3,
  input  lsu_pkg::lsu_stage_t dc4,
  input  lsu_pkg::lsu_stage_t dc5,
  output lsu_pkg::fwd_res_t   fwd
);

  lsu_pkg::lsu_stage_t older [3];  // index 0 is dc3, the youngest
  logic                ld_dc2;
  lsu_pkg::byteen_t    hit_lo_lo;  // store lo lane into load lo lane
  lsu_pkg::byteen_t    hit_hi_lo;  // store hi lane into load lo lane
  lsu_pkg::byteen_t    hit_lo_hi;
  lsu_pkg::byteen_t    hit_hi_hi;
  lsu_pkg::byteen_t    lo_hit;
  lsu_pkg::byteen_t    hi_hit;
  lsu_pkg::data_t      lo_fwd;
  lsu_pkg::data_t      hi_fwd;
  logic                lo_full;
  logic                hi_full;

  // bytes of one load lane that one store lane covers
  function automatic lsu_pkg::byteen_t lane_hit(lsu_pkg::dw_addr_t ld_dw,
                                                lsu_pkg::byteen_t  ld_be,
                                                lsu_pkg::dw_addr_t st_dw,
                                                lsu_pkg::byteen_t  st_be);
    lsu_pkg::byteen_t res;
    res = '0;
    if (ld_dw == st_dw) res = ld_be & st_be;
    return res;
  endfunction

  assign older[0] = dc3;
  assign older[1] = dc4;
  assign older[2] = dc5;

  assign ld_dc2 = dc2.valid & dc2.load;

  // *******************************************************************
  // per byte compare and priority mux
  // *******************************************************************
  always_comb begin
    lo_hit    = '0;
    hi_hit    = '0;
    lo_fwd    = '0;
    hi_fwd    = '0;
    hit_lo_lo = '0;
    hit_hi_lo = '0;
    hit_lo_hi = '0;
    hit_hi_hi = '0;
    // oldest first, a younger stage overwrites the bytes it also covers
    for (int s = 2; s >= 0; s--) begin
      if (ld_dc2 && older[s].valid && older[s].store) begin
        hit_lo_lo = lane_hit(dc2.lo_dw, dc2.lo_be, older[s].lo_dw, older[s].lo_be);
        hit_hi_lo = lane_hit(dc2.lo_dw, dc2.lo_be, older[s].hi_dw, older[s].hi_be);
        hit_lo_hi = lane_hit(dc2.hi_dw, dc2.hi_be, older[s].lo_dw, older[s].lo_be);
        hit_hi_hi = lane_hit(dc2.hi_dw, dc2.hi_be, older[s].hi_dw, older[s].hi_be);

        lo_fwd = lsu_pkg::byte_merge(lo_fwd, older[s].lo_data, hit_lo_lo);
        lo_fwd = lsu_pkg::byte_merge(lo_fwd, older[s].hi_data, hit_hi_lo);
        hi_fwd = lsu_pkg::byte_merge(hi_fwd, older[s].lo_data, hit_lo_hi);
        hi_fwd = lsu_pkg::byte_merge(hi_fwd, older[s].hi_data, hit_hi_hi);

        lo_hit = lo_hit | hit_lo_lo | hit_hi_lo;
        hi_hit = hi_hit | hit_lo_hi | hit_hi_hi;
      end
    end
  end

  // *******************************************************************
  // full hit and realignment
  // *******************************************************************
  assign lo_full = &(lo_hit | ~dc2.lo_be);
  assign hi_full = &(hi_hit | ~dc2.hi_be);  // hi_be is zero unless dual

  assign fwd.lo_hit   = lo_hit;
  assign fwd.hi_hit   = hi_hit;
  assign fwd.lo_fwd   = lo_fwd;
  assign fwd.hi_fwd   = hi_fwd;
  assign fwd.full_hit = ld_dc2 & lo_full & hi_full;
  assign fwd.data     = lsu_pkg::realign(hi_fwd, lo_fwd, dc2.hi_be, dc2.lo_be);

endmodule

/* source/lsu_pipe.sv */
// dc1 to dc5 stage registers of the load/store pipe
// freeze holds every stage, dc5_retire empties dc5 once its store is on the bus
// store data is carried as two dword lanes already shifted to their byte position
module lsu_pipe (
  input  logic                clk,
  input  logic                arst_n,
  input  lsu_pkg::lsu_req_t   req,
  input  lsu_pkg::fwd_res_t   fwd,
  input  logic                freeze,
  input  logic                dc5_retire,
  output lsu_pkg::lsu_stage_t dc2,
  output lsu_pkg::lsu_stage_t dc3,
  output lsu_pkg::lsu_stage_t dc4,
  output lsu_pkg::lsu_stage_t dc5,
  output lsu_pkg::fwd_res_t   dc3_fwd
);

  lsu_pkg::lsu_stage_t          dc1;
  lsu_pkg::lsu_stage_t          dc1_nxt;
  lsu_pkg::byteen_t             byteen;
  logic [2:0]                   last_ofs;   // size in bytes minus one
  logic [2*lsu_pkg::BYTE_W-1:0] byteen_ext;
  logic [2*lsu_pkg::DATA_W-1:0] data_ext;
  lsu_pkg::addr_t               end_addr;

  // *******************************************************************
  // byte enables and hi/lo split of the incoming request
  // *******************************************************************
  always_comb begin
    case (req.size)
      lsu_pkg::size_byte: begin
        byteen   = 8'b0000_0001;
        last_ofs = 3'd0;
      end
      lsu_pkg::size_half: begin
        byteen   = 8'b0000_0011;
        last_ofs = 3'd1;
      end
      lsu_pkg::size_word: begin
        byteen   = 8'b0000_1111;
        last_ofs = 3'd3;
      end
      default: begin
        byteen   = 8'b1111_1111;
        last_ofs = 3'd7;
      end
    endcase
  end

  assign byteen_ext = {8'b0, byteen} << req.addr[2:0];
  assign data_ext   = {64'b0, req.data} << {req.addr[2:0], 3'b000};
  assign end_addr   = req.addr + lsu_pkg::addr_t'(last_ofs);

  always_comb begin
    dc1_nxt.valid   = req.valid;
    dc1_nxt.load    = req.load;
    dc1_nxt.store   = req.store;
    dc1_nxt.tag     = req.tag;
    dc1_nxt.lo_dw   = req.addr[lsu_pkg::ADDR_W-1:3];
    dc1_nxt.hi_dw   = end_addr[lsu_pkg::ADDR_W-1:3];
    dc1_nxt.dual    = (req.addr[lsu_pkg::ADDR_W-1:3] != end_addr[lsu_pkg::ADDR_W-1:3]);
    dc1_nxt.lo_be   = byteen_ext[lsu_pkg::BYTE_W-1:0];
    dc1_nxt.hi_be   = byteen_ext[2*lsu_pkg::BYTE_W-1:lsu_pkg::BYTE_W];
    dc1_nxt.lo_data = data_ext[lsu_pkg::DATA_W-1:0];
    dc1_nxt.hi_data = data_ext[2*lsu_pkg::DATA_W-1:lsu_pkg::DATA_W];
  end

  // *******************************************************************
  // stage registers
  // *******************************************************************
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dc1     <= '0;
      dc2     <= '0;
      dc3     <= '0;
      dc4     <= '0;
      dc5     <= '0;
      dc3_fwd <= '0;
    end else begin
      if (!freeze) begin
        dc1     <= dc1_nxt;  // ready is ~freeze, so this is the accept
        dc2     <= dc1;
        dc3     <= dc2;
        dc3_fwd <= fwd;
        dc4     <= dc3;
      end
      // retire only comes while the pipe is frozen
      if (dc5_retire) begin
        dc5.valid <= 1'b0;
      end else if (!freeze) begin
        dc5 <= dc4;
      end
    end
  end

endmodule

/* source/lsu_bus_master.sv */
// Wishbone classic master, single transfers, one idle cycle between them
// a store in dc5 goes out first, then a dc3 load that is not a full hit is read
// returned dwords are merged byte by byte with the bytes forwarded at dc2
module lsu_bus_master (
  input  logic                clk,
  input  logic                arst_n,
  input  lsu_pkg::lsu_stage_t dc3,
  input  lsu_pkg::fwd_res_t   dc3_fwd,
  input  lsu_pkg::lsu_stage_t dc5,
  output logic                freeze,
  output logic                dc5_retire,
  output lsu_pkg::lsu_rsp_t   rsp,
  output lsu_pkg::wb_m2s_t    wb_o,
  input  lsu_pkg::wb_s2m_t    wb_i
);

  typedef enum logic [2:0] {
    st_idle,
    st_store_lo,
    st_store_hi,
    st_load_lo,
    st_load_hi,
    st_done
  } bus_state_e;

  bus_state_e        state;
  bus_state_e        state_nxt;
  logic              need_store;
  logic              need_load;
  logic              in_xfer;     // a transfer state, bus may be idle or busy
  logic              issue;
  logic              acked;
  logic              cyc_q;
  logic              we_q;
  lsu_pkg::dw_addr_t adr_q;
  lsu_pkg::data_t    dat_q;
  lsu_pkg::byteen_t  sel_q;
  lsu_pkg::data_t    lo_q;        // merged lo dword of a dual load
  lsu_pkg::data_t    lo_merged;
  lsu_pkg::data_t    hi_merged;
  lsu_pkg::data_t    rd_data;
  lsu_pkg::data_t    rsp_data_q;
  logic              fwd_rsp;

  assign need_store = dc5.valid & dc5.store;
  assign need_load  = dc3.valid & dc3.load & ~dc3_fwd.full_hit;

  assign in_xfer = (state == st_store_lo) | (state == st_store_hi) |
                   (state == st_load_lo)  | (state == st_load_hi);
  assign issue   = in_xfer & ~cyc_q;
  assign acked   = cyc_q & wb_i.ack;

  // pipe is let go in the done cycle, together with rsp.valid
  assign freeze = (state == st_idle) ? (need_store | need_load) : (state != st_done);

  assign dc5_retire = acked & (((state == st_store_lo) & ~dc5.dual) | (state == st_store_hi));

  // *******************************************************************
  // state machine
  // *******************************************************************
  always_comb begin
    state_nxt = state;
    case (state)
      st_idle: begin
        if (need_store) state_nxt = st_store_lo;
        else if (need_load) state_nxt = st_load_lo;
      end
      st_store_lo: if (acked) state_nxt = dc5.dual ? st_store_hi : st_idle;
      st_store_hi: if (acked) state_nxt = st_idle;
      st_load_lo:  if (acked) state_nxt = dc3.dual ? st_load_hi : st_done;
      st_load_hi:  if (acked) state_nxt = st_done;
      default:     state_nxt = st_idle;  // done lasts one cycle
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= st_idle;
      cyc_q <= 1'b0;
    end else begin
      state <= state_nxt;
      if (issue) cyc_q <= 1'b1;
      else if (acked) cyc_q <= 1'b0;  // drops for at least one cycle
    end
  end

  // *******************************************************************
  // transfer payload and read data merge
  // *******************************************************************
  assign lo_merged = lsu_pkg::byte_merge(wb_i.dat, dc3_fwd.lo_fwd, dc3_fwd.lo_hit);
  assign hi_merged = lsu_pkg::byte_merge(wb_i.dat, dc3_fwd.hi_fwd, dc3_fwd.hi_hit);
  assign rd_data   = lsu_pkg::realign(hi_merged, (state == st_load_hi) ? lo_q : lo_merged,
                                      dc3.hi_be, dc3.lo_be);

  always_ff @(posedge clk) begin
    if (issue) begin
      we_q  <= (state == st_store_lo) | (state == st_store_hi);
      adr_q <= (state == st_store_lo) ? dc5.lo_dw :
               (state == st_store_hi) ? dc5.hi_dw :
               (state == st_load_lo)  ? dc3.lo_dw : dc3.hi_dw;
      sel_q <= (state == st_store_lo) ? dc5.lo_be :
               (state == st_store_hi) ? dc5.hi_be :
               (state == st_load_lo)  ? dc3.lo_be : dc3.hi_be;
      dat_q <= (state == st_store_hi) ? dc5.hi_data : dc5.lo_data;
    end
    if (acked && state == st_load_lo) lo_q <= lo_merged;
    if (acked && state_nxt == st_done) rsp_data_q <= rd_data;
  end

  assign wb_o.cyc = cyc_q;
  assign wb_o.stb = cyc_q;
  assign wb_o.we  = we_q;
  assign wb_o.adr = adr_q;
  assign wb_o.dat = dat_q;
  assign wb_o.sel = sel_q;

  // full hit answers straight from the forwarded data as dc3 moves on
  assign fwd_rsp = dc3.valid & dc3.load & dc3_fwd.full_hit & ~freeze;

  assign rsp.valid = (state == st_done) | fwd_rsp;
  assign rsp.tag   = dc3.tag;  // the load is still held in dc3 in both cases
  assign rsp.data  = (state == st_done) ? rsp_data_q : dc3_fwd.data;

endmodule

/* source/lsu_fwd_top.sv */
// load/store forwarding unit for a 64-bit in-order pipe, Wishbone classic master
// a request is taken when req.valid and ready are both high
// full-hit loads answer two edges after acceptance, others freeze the pipe in dc3
module lsu_fwd_top (
  input  logic              clk,
  input  logic              arst_n,
  input  lsu_pkg::lsu_req_t req,
  output logic              ready,
  output lsu_pkg::lsu_rsp_t rsp,
  output lsu_pkg::wb_m2s_t  wb_o,
  input  lsu_pkg::wb_s2m_t  wb_i
);

  lsu_pkg::lsu_stage_t dc2;
  lsu_pkg::lsu_stage_t dc3;
  lsu_pkg::lsu_stage_t dc4;
  lsu_pkg::lsu_stage_t dc5;
  lsu_pkg::fwd_res_t   fwd;      // dc2 forward result
  lsu_pkg::fwd_res_t   dc3_fwd;  // registered copy for dc3
  logic                freeze;
  logic                dc5_retire;

  assign ready = ~freeze;  // back-pressure straight from the bus master

  // *******************************************************************
  // stage registers
  // *******************************************************************
  lsu_pipe u_pipe (
    .clk        (clk),
    .arst_n     (arst_n),
    .req        (req),
    .fwd        (fwd),
    .freeze     (freeze),
    .dc5_retire (dc5_retire),
    .dc2        (dc2),
    .dc3        (dc3),
    .dc4        (dc4),
    .dc5        (dc5),
    .dc3_fwd    (dc3_fwd)
  );

  // *******************************************************************
  // store to load forwarding at dc2
  // *******************************************************************
  lsu_fwd_match u_fwd (
    .dc2 (dc2),
    .dc3 (dc3),
    .dc4 (dc4),
    .dc5 (dc5),
    .fwd (fwd)
  );

  // *******************************************************************
  // bus side, dc5 stores and dc3 loads
  // *******************************************************************
  lsu_bus_master u_bus (
    .clk        (clk),
    .arst_n     (arst_n),
    .dc3        (dc3),
    .dc3_fwd    (dc3_fwd),
    .dc5        (dc5),
    .freeze     (freeze),
    .dc5_retire (dc5_retire),
    .rsp        (rsp),
    .wb_o       (wb_o),
    .wb_i       (wb_i)
  );

endmodule

/* tb/tb_wb_mem.sv */
// Wishbone classic slave with a byte memory of 2 KB, addresses alias above that
// ack comes 1 to 4 cycles after the request, held for one cycle
module tb_wb_mem (
  input  logic             clk,
  input  logic             arst_n,
  input  lsu_pkg::wb_m2s_t m2s,
  output lsu_pkg::wb_s2m_t s2m
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [7:0]     mem [0:2047];
  int             seed;
  int             wait_cnt;
  int             fill_idx;
  logic           pending;    // request seen, delay running
  logic [31:0]    rnd;
  lsu_pkg::data_t rd;

  // start value of a byte, every address bit takes part
  function automatic logic [7:0] init_pattern(logic [10:0] a);
    return a[7:0] ^ {a[10:8], a[10:6]};
  endfunction

  initial begin
    seed = 32'h564d_4a3d;
    for (fill_idx = 0; fill_idx < 2048; fill_idx++) begin
      mem[fill_idx] = init_pattern(11'(fill_idx));
    end
  end

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s2m      <= '0;
      pending  <= 1'b0;
      wait_cnt <= 0;
    end else begin
      s2m.ack <= 1'b0;
      if (m2s.cyc && m2s.stb && !s2m.ack) begin
        if (!pending) begin
          rnd      = $random(seed);
          pending  <= 1'b1;
          wait_cnt <= int'(rnd[1:0]);  // random ack delay
        end else if (wait_cnt == 0) begin
          pending <= 1'b0;
          s2m.ack <= 1'b1;
          for (int lane = 0; lane < 8; lane++) begin
            rd[8*lane +: 8] = mem[{m2s.adr[7:0], 3'(lane)}];
            if (m2s.we && m2s.sel[lane]) mem[{m2s.adr[7:0], 3'(lane)}] <= m2s.dat[8*lane +: 8];
          end
          s2m.dat <= rd;
        end else begin
          wait_cnt <= wait_cnt - 1;
        end
      end
    end
  end

endmodule

/* tb/tb_lsu_fwd.sv */
// testbench of the load/store forwarding unit with a Wishbone byte memory
// the reference is a byte array written in program order as requests are accepted
// all accesses stay below 2 KB, the bus memory aliases above that
module tb_lsu_fwd;
  timeunit 1ns;
  timeprecision 100ps;

  logic              clk;
  logic              arst_n;
  lsu_pkg::lsu_req_t req;
  logic              ready;
  lsu_pkg::lsu_rsp_t rsp;
  lsu_pkg::wb_m2s_t  wb_o;
  lsu_pkg::wb_s2m_t  wb_i;

  logic [7:0]        ref_mem [0:2047];
  lsu_pkg::tag_t     exp_tag_q [$];
  lsu_pkg::data_t    exp_data_q [$];
  int                exp_edge_q [$];  // accept edge, -1 when latency is free
  lsu_pkg::byteen_t  sel_log [$];     // sel of every acked transfer
  lsu_pkg::tag_t     next_tag;
  lsu_pkg::tag_t     got_tag;
  lsu_pkg::data_t    got_data;
  int                got_edge;
  int                seed;
  int                cycles;
  int                issued;
  int                loads;
  int                rsp_count;
  int                reads;
  int                errors;
  int                tests;
  int                tests_failed;
  int                err_mark;
  int                bus_mark;
  int                fill_idx;
  int                n;
  logic [31:0]       rnd;
  lsu_pkg::data_t    rnd_data;

  lsu_fwd_top u_lsu_fwd_top (
    .clk    (clk),
    .arst_n (arst_n),
    .req    (req),
    .ready  (ready),
    .rsp    (rsp),
    .wb_o   (wb_o),
    .wb_i   (wb_i)
  );

  tb_wb_mem u_mem (
    .clk    (clk),
    .arst_n (arst_n),
    .m2s    (wb_o),
    .s2m    (wb_i)
  );

  always #4 clk = ~clk;

  function automatic logic [7:0] init_pattern(logic [10:0] a);
    return a[7:0] ^ {a[10:8], a[10:6]};  // same start image as the bus memory
  endfunction

  task automatic mismatch(input string name, input logic [63:0] got, input logic [63:0] exp);
    $display("FAILED %s: got %h, expected %h", name, got, exp);
    errors++;
  endtask

  task automatic problem(input string msg);
    $display("%s", msg);
    errors++;
  endtask

  // *******************************************************************
  // monitors and run limit
  // *******************************************************************
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > 20 * issued + 200) begin
      $display("timeout after %0d cycles with %0d requests issued", cycles, issued);
      $display("** FAIL **");
      $finish;
    end
  end

  // rsp and the bus come from registers, so the falling edge sees settled values
  always @(negedge clk) begin
    if (arst_n) begin
      assert (wb_o.cyc == wb_o.stb) else problem("wb_o.cyc and wb_o.stb differ");
      if (wb_o.cyc && wb_i.ack) begin
        if (!wb_o.we) reads++;
        sel_log.push_back(wb_o.sel);
      end
      if (rsp.valid) begin
        assert (exp_tag_q.size() != 0) else problem("response with no load outstanding");
        if (exp_tag_q.size() != 0) begin
          got_tag  = exp_tag_q.pop_front();
          got_data = exp_data_q.pop_front();
          got_edge = exp_edge_q.pop_front();
          assert (rsp.tag == got_tag) else mismatch("rsp.tag", 64'(rsp.tag), 64'(got_tag));
          assert (rsp.data == got_data) else mismatch("rsp.data", rsp.data, got_data);
          if (got_edge >= 0) begin
            assert (cycles - got_edge == 2)
              else problem($sformatf("load answered %0d edges after acceptance, not 2",
                                     cycles - got_edge));
          end
          rsp_count++;
        end
      end
    end
  end

  // *******************************************************************
  // stimulus
  // *******************************************************************
  task automatic send(input logic store, input lsu_pkg::ldst_size_e size,
                      input lsu_pkg::addr_t addr, input lsu_pkg::data_t data,
                      input logic chk_lat);
    int             nb;
    lsu_pkg::addr_t idx;
    lsu_pkg::data_t val;
    @(negedge clk);
    req.valid = 1'b1;
    req.load  = ~store;
    req.store = store;
    req.size  = size;
    req.tag   = next_tag;
    req.addr  = addr;
    req.data  = data;
    while (!ready) @(negedge clk);  // held until taken
    nb  = 1 << int'(size);
    val = '0;
    for (int i = 0; i < nb; i++) begin
      idx = addr + i;
      if (store) ref_mem[idx[10:0]] = data[8*i +: 8];
      else val[8*i +: 8] = ref_mem[idx[10:0]];
    end
    if (!store) begin
      exp_tag_q.push_back(next_tag);
      exp_data_q.push_back(val);
      exp_edge_q.push_back(chk_lat ? cycles + 1 : -1);
      loads++;
    end
    next_tag++;
    issued++;
  endtask

  task automatic idle(input int count);
    repeat (count) begin
      @(negedge clk);
      req.valid = 1'b0;
    end
  endtask

  // wait until the pipe has run empty and the bus is idle
  task automatic drain;
    int quiet;
    quiet = 0;
    while (quiet < 8) begin
      @(negedge clk);
      req.valid = 1'b0;
      if (ready && !wb_o.cyc) quiet++;
      else quiet = 0;
    end
  endtask

  task automatic check_split(input lsu_pkg::addr_t addr, input lsu_pkg::ldst_size_e size);
    logic [15:0] be;
    be = ((16'h1 << (1 << int'(size))) - 16'h1) << addr[2:0];
    assert (sel_log.size() == 2) else problem("misaligned access did not make two transfers");
    if (sel_log.size() == 2) begin
      assert (sel_log[0] == be[7:0]) else mismatch("wb_o.sel lo", 64'(sel_log[0]), 64'(be[7:0]));
      assert (sel_log[1] == be[15:8]) else mismatch("wb_o.sel hi", 64'(sel_log[1]), 64'(be[15:8]));
    end
    sel_log.delete();
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests++;
    if (errors == err_before) begin
      $display("test %0d %s: ok", tests, name);
    end else begin
      $display("test %0d %s: %0d errors", tests, name, errors - err_before);
      tests_failed++;
    end
  endtask

  initial begin
    clk    = 1'b0;
    arst_n = 1'b0;
    req    = '0;
    seed   = 32'h564d_4a3d;
    {cycles, issued, loads, rsp_count, reads, errors, tests, tests_failed} = '0;
    next_tag = '0;
    for (fill_idx = 0; fill_idx < 2048; fill_idx++) begin
      ref_mem[fill_idx] = init_pattern(11'(fill_idx));
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    err_mark = errors;
    @(negedge clk);
    assert (!rsp.valid) else mismatch("rsp.valid", 64'(rsp.valid), 64'h0);
    assert (!wb_o.cyc) else mismatch("wb_o.cyc", 64'(wb_o.cyc), 64'h0);
    assert (!u_lsu_fwd_top.freeze) else mismatch("freeze", 64'(u_lsu_fwd_top.freeze), 64'h0);
    assert (ready) else mismatch("ready", 64'(ready), 64'h1);
    finish_test("reset state", err_mark);

    // store in dc3, then dc4, then dc5 when the load is in dc2
    err_mark = errors;
    bus_mark = reads;
    send(1'b1, lsu_pkg::size_dword, 32'h100, 64'h1122_3344_5566_7788, 1'b0);
    send(1'b0, lsu_pkg::size_word, 32'h104, '0, 1'b1);
    drain();
    send(1'b1, lsu_pkg::size_word, 32'h120, 64'h0000_0000_a1b2_c3d4, 1'b0);
    idle(1);
    send(1'b0, lsu_pkg::size_half, 32'h122, '0, 1'b0);
    drain();
    assert (reads == bus_mark) else problem("a fully forwarded load went to the bus");
    send(1'b1, lsu_pkg::size_dword, 32'h140, 64'h0f1e_2d3c_4b5a_6978, 1'b0);
    idle(2);
    send(1'b0, lsu_pkg::size_dword, 32'h140, '0, 1'b0);
    drain();
    finish_test("full hit forward", err_mark);

    err_mark = errors;
    send(1'b1, lsu_pkg::size_dword, 32'h40, 64'hdead_beef_cafe_f00d, 1'b0);
    send(1'b1, lsu_pkg::size_word, 32'h42, 64'h0000_0000_1357_9bdf, 1'b0);
    send(1'b1, lsu_pkg::size_byte, 32'h43, 64'h0000_0000_0000_00e7, 1'b0);
    send(1'b0, lsu_pkg::size_dword, 32'h40, '0, 1'b0);
    send(1'b0, lsu_pkg::size_half, 32'h42, '0, 1'b0);
    drain();
    finish_test("youngest store wins", err_mark);

    err_mark = errors;
    bus_mark = reads;
    send(1'b1, lsu_pkg::size_byte, 32'h81, 64'h0000_0000_0000_005c, 1'b0);
    send(1'b0, lsu_pkg::size_dword, 32'h80, '0, 1'b0);
    send(1'b1, lsu_pkg::size_half, 32'h10f, 64'h0000_0000_0000_9a8b, 1'b0);
    send(1'b0, lsu_pkg::size_word, 32'h10e, '0, 1'b0);
    drain();
    assert (reads > bus_mark) else problem("partly covered loads made no bus read");
    finish_test("partial hit merge", err_mark);

    err_mark = errors;
    sel_log.delete();
    send(1'b1, lsu_pkg::size_dword, 32'h205, 64'h8877_6655_4433_2211, 1'b0);
    drain();
    check_split(32'h205, lsu_pkg::size_dword);
    send(1'b0, lsu_pkg::size_word, 32'h2fe, '0, 1'b0);
    drain();
    check_split(32'h2fe, lsu_pkg::size_word);
    finish_test("dword crossing split", err_mark);

    // random mix in a 256 byte window so that many loads hit stores
    err_mark = errors;
    for (n = 0; n < 200; n++) begin
      rnd            = $random(seed);
      rnd_data[31:0]  = $random(seed);
      rnd_data[63:32] = $random(seed);
      send(rnd[0], lsu_pkg::ldst_size_e'(rnd[2:1]), {24'b0, rnd[10:3]}, rnd_data, 1'b0);
      if (rnd[13:12] == 2'b00) idle(1);
    end
    drain();
    assert (rsp_count == loads) else problem("some loads never answered");
    finish_test("random mix", err_mark);

    $display("%0d tests, %0d failed, %0d check errors, %0d responses",
             tests, tests_failed, errors, rsp_count);
    if (errors == 0 && tests_failed == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* vlog.f */
common/lsu_pkg.sv
fwd/lsu_fwd_match.sv
source/lsu_pipe.sv
source/lsu_bus_master.sv
source/lsu_fwd_top.sv
tb/tb_wb_mem.sv
tb/tb_lsu_fwd.sv

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
# the result is taken from the log, the testbench prints its verdict there
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_lsu_fwd -f vlog.f -o tb_lsu_fwd

./obj_dir/tb_lsu_fwd > sim.log 2>&1
cat sim.log

if grep -qxF '** PASS **' sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi
